/* src/rv64_exec_params.svh */
// rv64 exec parameters giving the data width and the RV64IM opcode and funct codes
`ifndef RV64_EXEC_PARAMS_SVH
`define RV64_EXEC_PARAMS_SVH

`define XLEN 64

// major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_IMM32  7'b0011011
`define OP_REG    7'b0110011
`define OP_REG32  7'b0111011
`define OP_SYSTEM 7'b1110011

// integer funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// load funct3
`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LD  3'b011
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_LWU 3'b110

`define F7_BASE   7'b0000000
`define F7_ALT    7'b0100000
`define F7_MULDIV 7'b0000001

`endif

/* src/rv64_exec_pkg.sv */
// rv64 exec types for op selects, instruction formats and the decode to execute issue
`include "rv64_exec_params.svh"

package rv64_exec_pkg;

  // mul through remu must stay in funct3 order
  typedef enum logic [4:0] {
    ALU_COPY, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_op_e;

  typedef enum logic [2:0] {
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD
  } mem_op_e;

  typedef enum logic {ASRC_RS1, ASRC_PC} asrc_e;

  typedef enum logic [1:0] {BSRC_RS2, BSRC_IMM, BSRC_FOUR} bsrc_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata;
    alu_op_e          alu;
    br_op_e           br;
    mem_op_e          mem;
    asrc_e            asrc;
    bsrc_e            bsrc;
    logic             word_cut;
    logic             mem_to_reg;
    logic             ebreak;
    logic             illegal;
  } issue_t;

endpackage

/* src/rv64_idu.sv */
// rv64 decode unit that turns one instruction word into an execute issue
`include "rv64_exec_params.svh"

module rv64_idu (
  input  logic                  i_valid,
  input  rv64_exec_pkg::inst_u  i_inst,
  input  logic [`XLEN-1:0]      i_pc,
  input  logic [`XLEN-1:0]      i_rs1_val,
  input  logic [`XLEN-1:0]      i_rs2_val,
  input  logic [`XLEN-1:0]      i_rdata,
  output logic                  o_valid,
  output rv64_exec_pkg::issue_t o_issue
);
  import rv64_exec_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [6:0]       shift_f7;
  logic             is_word;
  logic             is_reg;
  logic             is_ebreak;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      `F3_ADD:  return ALU_ADD;
      `F3_SLL:  return ALU_SLL;
      `F3_SLT:  return ALU_SLT;
      `F3_SLTU: return ALU_SLTU;
      `F3_XOR:  return ALU_XOR;
      `F3_SR:   return ALU_SRL;
      `F3_OR:   return ALU_OR;
      `F3_AND:  return ALU_AND;
      default:  return ALU_ADD;
    endcase
  endfunction

  assign opcode = i_inst.r_fmt.opcode;
  assign funct3 = i_inst.r_fmt.funct3;
  assign funct7 = i_inst.r_fmt.funct7;

  // rv64 shamt takes bit 25 in op-imm
  assign shift_f7 = (opcode == `OP_IMM) ? {funct7[6:1], 1'b0} : funct7;
  assign is_word  = (opcode == `OP_IMM32) || (opcode == `OP_REG32);
  assign is_reg   = (opcode == `OP_REG) || (opcode == `OP_REG32);

  assign imm_i = {{(`XLEN-12){i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
  assign imm_s = {{(`XLEN-12){i_inst.s_fmt.imm_hi[6]}}, i_inst.s_fmt.imm_hi,
                  i_inst.s_fmt.imm_lo};
  assign imm_b = {{(`XLEN-12){i_inst.b_fmt.imm12}}, i_inst.b_fmt.imm11,
                  i_inst.b_fmt.imm10_5, i_inst.b_fmt.imm4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst.u_fmt.imm[19]}}, i_inst.u_fmt.imm, 12'b0};
  assign imm_j = {{(`XLEN-20){i_inst.j_fmt.imm20}}, i_inst.j_fmt.imm19_12,
                  i_inst.j_fmt.imm11, i_inst.j_fmt.imm10_1, 1'b0};

  assign is_ebreak = (i_inst.i_fmt.imm == 12'h001) && (i_inst.i_fmt.rs1 == 5'd0) &&
                     (i_inst.i_fmt.funct3 == 3'd0) && (i_inst.i_fmt.rd == 5'd0);

  assign o_valid = i_valid;

  always_comb begin
    o_issue       = '0;
    o_issue.pc    = i_pc;
    o_issue.rs1   = i_rs1_val;
    o_issue.rs2   = i_rs2_val;
    o_issue.rdata = i_rdata;
    o_issue.alu   = ALU_ADD;
    o_issue.br    = BR_NONE;
    o_issue.mem   = MEM_LD;
    o_issue.asrc  = ASRC_RS1;
    o_issue.bsrc  = BSRC_RS2;
    case (opcode)
      `OP_LUI: begin
        o_issue.imm = imm_u;
        o_issue.alu = ALU_COPY;
      end
      `OP_AUIPC: begin
        o_issue.imm  = imm_u;
        o_issue.asrc = ASRC_PC;
        o_issue.bsrc = BSRC_IMM;
      end
      `OP_JAL, `OP_JALR: begin
        // link value pc+4 comes out of the alu
        o_issue.imm     = (opcode == `OP_JAL) ? imm_j : imm_i;
        o_issue.br      = (opcode == `OP_JAL) ? BR_JAL : BR_JALR;
        o_issue.asrc    = ASRC_PC;
        o_issue.bsrc    = BSRC_FOUR;
        o_issue.illegal = (opcode == `OP_JALR) && (funct3 != 3'b000);
      end
      `OP_BRANCH: begin
        o_issue.imm = imm_b;
        o_issue.alu = ALU_SUB;
        case (funct3)
          `F3_BEQ:  o_issue.br = BR_BEQ;
          `F3_BNE:  o_issue.br = BR_BNE;
          `F3_BLT:  o_issue.br = BR_BLT;
          `F3_BGE:  o_issue.br = BR_BGE;
          `F3_BLTU: o_issue.br = BR_BLTU;
          `F3_BGEU: o_issue.br = BR_BGEU;
          default:  o_issue.illegal = 1'b1;
        endcase
      end
      `OP_LOAD: begin
        o_issue.imm        = imm_i;
        o_issue.bsrc       = BSRC_IMM;
        o_issue.mem_to_reg = 1'b1;
        case (funct3)
          `F3_LB:  o_issue.mem = MEM_LB;
          `F3_LH:  o_issue.mem = MEM_LH;
          `F3_LW:  o_issue.mem = MEM_LW;
          `F3_LD:  o_issue.mem = MEM_LD;
          `F3_LBU: o_issue.mem = MEM_LBU;
          `F3_LHU: o_issue.mem = MEM_LHU;
          `F3_LWU: o_issue.mem = MEM_LWU;
          default: o_issue.illegal = 1'b1;
        endcase
      end
      `OP_STORE: begin
        // address only
        o_issue.imm     = imm_s;
        o_issue.bsrc    = BSRC_IMM;
        o_issue.illegal = funct3[2];
      end
      `OP_IMM, `OP_IMM32, `OP_REG, `OP_REG32: begin
        o_issue.word_cut = is_word;
        if (!is_reg) begin
          o_issue.imm  = imm_i;
          o_issue.bsrc = BSRC_IMM;
        end
        if (is_reg && funct7 == `F7_MULDIV) begin
          o_issue.alu     = alu_op_e'(ALU_MUL + 5'(funct3));
          // no mulh forms in op-32
          o_issue.illegal = is_word && (funct3 != 3'b000) && !funct3[2];
        end else begin
          o_issue.alu = base_op(funct3);
          case (funct3)
            `F3_ADD: begin
              if (is_reg && funct7 == `F7_ALT)
                o_issue.alu = ALU_SUB;
              else
                o_issue.illegal = is_reg && (funct7 != `F7_BASE);
            end
            `F3_SLL: o_issue.illegal = shift_f7 != `F7_BASE;
            `F3_SR: begin
              if (shift_f7 == `F7_ALT)
                o_issue.alu = ALU_SRA;
              else
                o_issue.illegal = shift_f7 != `F7_BASE;
            end
            default: o_issue.illegal = is_word || (is_reg && funct7 != `F7_BASE);
          endcase
        end
      end
      `OP_SYSTEM: begin
        o_issue.ebreak  = is_ebreak;
        o_issue.illegal = !is_ebreak;
      end
      default: o_issue.illegal = 1'b1;
    endcase
  end

endmodule

/* src/rv64_issue_reg.sv */
// rv64 decode to execute pipeline register with sticky halt after ebreak
module rv64_issue_reg (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  rv64_exec_pkg::issue_t i_issue,
  output logic                  o_valid,
  output rv64_exec_pkg::issue_t o_issue,
  output logic                  o_halt
);

  logic halt_q;
  logic accept;

  // halt shows with the ebreak result, then holds
  assign o_halt = halt_q | (o_valid & o_issue.ebreak);
  assign accept = i_valid & ~o_halt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      halt_q  <= 1'b0;
    end else begin
      o_valid <= accept;
      halt_q  <= o_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept)
      o_issue <= i_issue;
  end

endmodule

/* src/rv64_exu.sv */
// rv64 execute unit that computes ALU and M results, next PC and the write-back value
`include "rv64_exec_params.svh"

module rv64_exu (
  input  rv64_exec_pkg::issue_t i_issue,
  output logic [`XLEN-1:0]      o_busw,
  output logic [`XLEN-1:0]      o_alu_result,
  output logic [`XLEN-1:0]      o_nextpc
);
  import rv64_exec_pkg::*;

  localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

  logic [`XLEN-1:0]          src_a, src_b;
  logic [`XLEN-1:0]          ua, ub, sa, sb;
  logic [5:0]                shamt;
  logic [2*`XLEN-1:0]        prod_uu;
  logic signed [2*`XLEN-1:0] prod_ss, prod_su;
  logic signed [`XLEN-1:0]   quo_raw, rem_raw;
  logic                      div_zero, div_ovf;
  logic [`XLEN-1:0]          alu_raw;
  logic [`XLEN-1:0]          load_val;
  logic                      taken;

  assign src_a = (i_issue.asrc == ASRC_PC) ? i_issue.pc : i_issue.rs1;

  always_comb begin
    case (i_issue.bsrc)
      BSRC_IMM:  src_b = i_issue.imm;
      BSRC_FOUR: src_b = `XLEN'(4);
      default:   src_b = i_issue.rs2;
    endcase
  end

  // W ops work on the low word, zero extended for unsigned ops, sign for signed
  assign ua = i_issue.word_cut ? {{(`XLEN-32){1'b0}}, src_a[31:0]} : src_a;
  assign ub = i_issue.word_cut ? {{(`XLEN-32){1'b0}}, src_b[31:0]} : src_b;
  assign sa = i_issue.word_cut ? {{(`XLEN-32){src_a[31]}}, src_a[31:0]} : src_a;
  assign sb = i_issue.word_cut ? {{(`XLEN-32){src_b[31]}}, src_b[31:0]} : src_b;

  assign shamt = i_issue.word_cut ? {1'b0, ub[4:0]} : ub[5:0];

  assign prod_uu = ua * ub;
  assign prod_ss = $signed(sa) * $signed(sb);
  assign prod_su = $signed(sa) * $signed({1'b0, ub});

  assign div_zero = (ub == '0);
  assign div_ovf  = (sa == MIN_NEG) && (sb == '1);
  assign quo_raw  = $signed(sa) / $signed(sb);
  assign rem_raw  = $signed(sa) % $signed(sb);

  always_comb begin
    case (i_issue.alu)
      ALU_COPY:   alu_raw = i_issue.imm;
      ALU_ADD:    alu_raw = ua + ub;
      ALU_SUB:    alu_raw = ua - ub;
      ALU_SLT:    alu_raw = {{(`XLEN-1){1'b0}}, $signed(sa) < $signed(sb)};
      ALU_SLTU:   alu_raw = {{(`XLEN-1){1'b0}}, ua < ub};
      ALU_XOR:    alu_raw = ua ^ ub;
      ALU_OR:     alu_raw = ua | ub;
      ALU_AND:    alu_raw = ua & ub;
      ALU_SLL:    alu_raw = ua << shamt;
      ALU_SRL:    alu_raw = ua >> shamt;
      ALU_SRA:    alu_raw = $signed(sa) >>> shamt;
      ALU_MUL:    alu_raw = prod_uu[`XLEN-1:0];
      ALU_MULH:   alu_raw = prod_ss[2*`XLEN-1:`XLEN];
      ALU_MULHSU: alu_raw = prod_su[2*`XLEN-1:`XLEN];
      ALU_MULHU:  alu_raw = prod_uu[2*`XLEN-1:`XLEN];
      // divide by zero and overflow per the M spec
      ALU_DIV:    alu_raw = div_zero ? '1 : (div_ovf ? sa : quo_raw);
      ALU_DIVU:   alu_raw = div_zero ? '1 : ua / ub;
      ALU_REM:    alu_raw = div_zero ? sa : (div_ovf ? '0 : rem_raw);
      ALU_REMU:   alu_raw = div_zero ? ua : ua % ub;
      default:    alu_raw = ua + ub;
    endcase
  end

  assign o_alu_result = i_issue.word_cut ? {{(`XLEN-32){alu_raw[31]}}, alu_raw[31:0]}
                                         : alu_raw;

  // branches compare the raw register values
  always_comb begin
    case (i_issue.br)
      BR_JAL:  taken = 1'b1;
      BR_BEQ:  taken = i_issue.rs1 == i_issue.rs2;
      BR_BNE:  taken = i_issue.rs1 != i_issue.rs2;
      BR_BLT:  taken = $signed(i_issue.rs1) < $signed(i_issue.rs2);
      BR_BGE:  taken = $signed(i_issue.rs1) >= $signed(i_issue.rs2);
      BR_BLTU: taken = i_issue.rs1 < i_issue.rs2;
      BR_BGEU: taken = i_issue.rs1 >= i_issue.rs2;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_issue.br == BR_JALR)
      o_nextpc = (i_issue.rs1 + i_issue.imm) & ~`XLEN'(1);
    else if (taken)
      o_nextpc = i_issue.pc + i_issue.imm;
    else
      o_nextpc = i_issue.pc + `XLEN'(4);
  end

  always_comb begin
    case (i_issue.mem)
      MEM_LB:  load_val = {{(`XLEN-8){i_issue.rdata[7]}}, i_issue.rdata[7:0]};
      MEM_LBU: load_val = {{(`XLEN-8){1'b0}}, i_issue.rdata[7:0]};
      MEM_LH:  load_val = {{(`XLEN-16){i_issue.rdata[15]}}, i_issue.rdata[15:0]};
      MEM_LHU: load_val = {{(`XLEN-16){1'b0}}, i_issue.rdata[15:0]};
      MEM_LW:  load_val = {{(`XLEN-32){i_issue.rdata[31]}}, i_issue.rdata[31:0]};
      MEM_LWU: load_val = {{(`XLEN-32){1'b0}}, i_issue.rdata[31:0]};
      default: load_val = i_issue.rdata;
    endcase
  end

  assign o_busw = i_issue.mem_to_reg ? load_val : o_alu_result;

endmodule

/* src/rv64_exec_top.sv */
// rv64 exec top that chains decode, the issue register and execute
`include "rv64_exec_params.svh"

module rv64_exec_top (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_valid,
  input  logic [31:0]      i_inst,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_rs1_val,
  input  logic [`XLEN-1:0] i_rs2_val,
  input  logic [`XLEN-1:0] i_rdata,
  output logic             o_valid,
  output logic [`XLEN-1:0] o_busw,
  output logic [`XLEN-1:0] o_alu_result,
  output logic [`XLEN-1:0] o_nextpc,
  output logic             o_halt,
  output logic             o_illegal
);
  import rv64_exec_pkg::*;

  issue_t           dec_issue, ex_issue;
  logic             dec_valid, ex_valid;
  logic [`XLEN-1:0] ex_busw, ex_alu_result, ex_nextpc;

  rv64_idu idu_i (
    .i_valid   (i_valid),
    .i_inst    (i_inst),
    .i_pc      (i_pc),
    .i_rs1_val (i_rs1_val),
    .i_rs2_val (i_rs2_val),
    .i_rdata   (i_rdata),
    .o_valid   (dec_valid),
    .o_issue   (dec_issue)
  );

  rv64_issue_reg issue_reg_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (dec_valid),
    .i_issue (dec_issue),
    .o_valid (ex_valid),
    .o_issue (ex_issue),
    .o_halt  (o_halt)
  );

  rv64_exu exu_i (
    .i_issue      (ex_issue),
    .o_busw       (ex_busw),
    .o_alu_result (ex_alu_result),
    .o_nextpc     (ex_nextpc)
  );

  // results only count with a valid issue
  assign o_valid      = ex_valid;
  assign o_busw       = ex_valid ? ex_busw : '0;
  assign o_alu_result = ex_valid ? ex_alu_result : '0;
  assign o_nextpc     = ex_valid ? ex_nextpc : '0;
  assign o_illegal    = ex_valid & ex_issue.illegal;

endmodule

/* dv/rv64_exec_checker.sv */
// rv64 exec checker with its own RV64IM model that compares every DUT result
`include "rv64_exec_params.svh"

module rv64_exec_checker (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_valid,
  input  logic [31:0]      i_inst,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_rs1_val,
  input  logic [`XLEN-1:0] i_rs2_val,
  input  logic [`XLEN-1:0] i_rdata,
  input  logic             i_out_valid,
  input  logic [`XLEN-1:0] i_busw,
  input  logic [`XLEN-1:0] i_alu_result,
  input  logic [`XLEN-1:0] i_nextpc,
  input  logic             i_halt,
  input  logic             i_illegal,
  input  logic             i_done,
  output int               o_checks,
  output int               o_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic             cap_rst = 1'b1;
  logic             cap_valid;
  logic [31:0]      cap_inst;
  logic [`XLEN-1:0] cap_pc, cap_a, cap_b, cap_rdata;
  logic             halt;
  logic             exp_valid;
  logic [`XLEN-1:0] exp_alu, exp_busw, exp_npc;
  logic             exp_ill, exp_ebrk, chk_alu, chk_busw, chk_npc;
  string            name;

  initial begin
    o_checks = 0;
    o_errors = 0;
    halt     = 1'b0;
  end

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] div_calc(input logic [63:0] a, input logic [63:0] b,
                                           input logic sgn, input logic rem);
    logic signed [63:0] sa, sb;
    sa = a;
    sb = b;
    if (b == 64'd0)
      return rem ? a : '1;
    if (sgn && a == 64'h8000_0000_0000_0000 && b == '1)
      return rem ? 64'd0 : a;
    if (sgn)
      return rem ? 64'(sa % sb) : 64'(sa / sb);
    return rem ? a % b : a / b;
  endfunction

  function automatic logic [63:0] mul_calc(input logic [63:0] a, input logic [63:0] b,
                                           input logic [2:0] f3);
    logic [127:0] p;
    case (f3)
      3'd1: p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
      3'd2: p = {{64{a[63]}}, a} * {64'd0, b};
      default: p = {64'd0, a} * {64'd0, b};
    endcase
    return (f3 == 3'd0) ? p[63:0] : p[127:64];
  endfunction

  function automatic logic [63:0] mext_calc(input logic [63:0] a, input logic [63:0] b,
                                            input logic [2:0] f3, input logic word);
    logic [63:0] ae, be, q;
    if (!word) begin
      if (!f3[2])
        return mul_calc(a, b, f3);
      return div_calc(a, b, !f3[0], f3[1]);
    end
    // word forms extend the low halves, then sign-extend the low 32 result bits
    ae = f3[0] ? {32'd0, a[31:0]} : sext32(a[31:0]);
    be = f3[0] ? {32'd0, b[31:0]} : sext32(b[31:0]);
    if (!f3[2])
      return sext32(32'(a[31:0] * b[31:0]));
    q = div_calc(ae, be, !f3[0], f3[1]);
    return sext32(q[31:0]);
  endfunction

  function automatic logic [63:0] base_calc(input logic [63:0] a, input logic [63:0] b,
                                            input logic [2:0] f3, input logic alt,
                                            input logic word);
    logic        [31:0] r32;
    logic signed [31:0] s32;
    logic signed [63:0] s64;
    s32 = a[31:0];
    s64 = a;
    if (word) begin
      case (f3)
        3'd1:    r32 = a[31:0] << b[4:0];
        3'd5:    r32 = alt ? 32'(s32 >>> b[4:0]) : a[31:0] >> b[4:0];
        default: r32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      endcase
      return sext32(r32);
    end
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[5:0];
      3'd2: return {63'd0, $signed(a) < $signed(b)};
      3'd3: return {63'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 64'(s64 >>> b[5:0]) : a >> b[5:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [63:0] load_ext(input logic [63:0] d, input logic [2:0] f3);
    case (f3)
      3'd0:    return {{56{d[7]}}, d[7:0]};
      3'd1:    return {{48{d[15]}}, d[15:0]};
      3'd2:    return sext32(d[31:0]);
      3'd4:    return {56'd0, d[7:0]};
      3'd5:    return {48'd0, d[15:0]};
      3'd6:    return {32'd0, d[31:0]};
      default: return d;
    endcase
  endfunction

  function automatic string test_name(input logic [31:0] w);
    case (w[6:0])
      `OP_REG:    return (w[31:25] == `F7_MULDIV) ? "m_ext" : "alu_reg";
      `OP_REG32:  return (w[31:25] == `F7_MULDIV) ? "m_ext_word" : "alu_word";
      `OP_IMM:    return "alu_imm";
      `OP_IMM32:  return "alu_imm_word";
      `OP_LOAD:   return "load";
      `OP_STORE:  return "store";
      `OP_BRANCH: return "branch";
      `OP_JAL:    return "jal";
      `OP_JALR:   return "jalr";
      `OP_LUI:    return "lui";
      `OP_AUIPC:  return "auipc";
      `OP_SYSTEM: return "ebreak";
      default:    return "illegal";
    endcase
  endfunction

  task automatic run_model(input logic [31:0] w, input logic [63:0] pc,
                           input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] rdata);
    logic [2:0]  f3;
    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        alt, is_reg;
    f3     = w[14:12];
    imm_i  = {{52{w[31]}}, w[31:20]};
    imm_s  = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_b  = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u  = sext32({w[31:12], 12'd0});
    imm_j  = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    is_reg = (w[6:0] == `OP_REG) || (w[6:0] == `OP_REG32);
    alt    = w[30] && ((f3 == 3'd5) || (is_reg && f3 == 3'd0));
    exp_alu  = '0;
    exp_npc  = pc + 64'd4;
    exp_ill  = 1'b0;
    exp_ebrk = 1'b0;
    chk_alu  = 1'b1;
    chk_busw = 1'b1;
    chk_npc  = 1'b1;
    case (w[6:0])
      `OP_REG, `OP_REG32: begin
        if (w[31:25] == `F7_MULDIV)
          exp_alu = mext_calc(a, b, f3, w[6:0] == `OP_REG32);
        else
          exp_alu = base_calc(a, b, f3, alt, w[6:0] == `OP_REG32);
      end
      `OP_IMM:   exp_alu = base_calc(a, imm_i, f3, alt, 1'b0);
      `OP_IMM32: exp_alu = base_calc(a, imm_i, f3, alt, 1'b1);
      `OP_LUI:   exp_alu = imm_u;
      `OP_AUIPC: exp_alu = pc + imm_u;
      `OP_JAL: begin
        exp_alu = pc + 64'd4;
        exp_npc = pc + imm_j;
      end
      `OP_JALR: begin
        exp_alu = pc + 64'd4;
        exp_npc = (a + imm_i) & ~64'd1;
      end
      `OP_BRANCH: begin
        chk_alu  = 1'b0;
        chk_busw = 1'b0;
        case (f3)
          3'd0: if (a == b) exp_npc = pc + imm_b;
          3'd1: if (a != b) exp_npc = pc + imm_b;
          3'd4: if ($signed(a) < $signed(b)) exp_npc = pc + imm_b;
          3'd5: if ($signed(a) >= $signed(b)) exp_npc = pc + imm_b;
          3'd6: if (a < b) exp_npc = pc + imm_b;
          default: if (a >= b) exp_npc = pc + imm_b;
        endcase
      end
      `OP_LOAD:  exp_alu = a + imm_i;
      `OP_STORE: begin
        exp_alu  = a + imm_s;
        chk_busw = 1'b0;
      end
      default: begin
        // ebreak and illegal words only raise flags
        exp_ebrk = (w == 32'h0010_0073);
        exp_ill  = !exp_ebrk;
        chk_alu  = 1'b0;
        chk_busw = 1'b0;
        chk_npc  = 1'b0;
      end
    endcase
    exp_busw = (w[6:0] == `OP_LOAD) ? load_ext(rdata, f3) : exp_alu;
  endtask

  task automatic check_val(input string test, input string field,
                           input logic [63:0] exp, input logic [63:0] act);
    o_checks++;
    if (exp !== act) begin
      o_errors++;
      $display("error %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  always @(posedge i_clk) begin
    cap_rst   <= i_rst;
    cap_valid <= i_valid;
    cap_inst  <= i_inst;
    cap_pc    <= i_pc;
    cap_a     <= i_rs1_val;
    cap_b     <= i_rs2_val;
    cap_rdata <= i_rdata;
  end

  // outputs are settled by the falling edge
  always @(negedge i_clk) begin
    if (cap_rst) begin
      halt = 1'b0;
      check_val("reset", "o_valid", 64'd0, {63'd0, i_out_valid});
      check_val("reset", "o_halt", 64'd0, {63'd0, i_halt});
      check_val("reset", "o_illegal", 64'd0, {63'd0, i_illegal});
    end else begin
      exp_valid = cap_valid && !halt;
      check_val("timing", "o_valid", {63'd0, exp_valid}, {63'd0, i_out_valid});
      if (exp_valid) begin
        run_model(cap_inst, cap_pc, cap_a, cap_b, cap_rdata);
        name = test_name(cap_inst);
        if (chk_alu)
          check_val(name, "o_alu_result", exp_alu, i_alu_result);
        if (chk_busw)
          check_val(name, "o_busw", exp_busw, i_busw);
        if (chk_npc)
          check_val(name, "o_nextpc", exp_npc, i_nextpc);
        check_val(name, "o_illegal", {63'd0, exp_ill}, {63'd0, i_illegal});
        if (exp_ebrk)
          halt = 1'b1;
      end else begin
        check_val("idle", "o_illegal", 64'd0, {63'd0, i_illegal});
      end
      check_val("halt", "o_halt", {63'd0, halt}, {63'd0, i_halt});
    end
  end

  always @(posedge i_done) begin
    $display("checks %0d errors %0d", o_checks, o_errors);
  end

endmodule

/* dv/rv64_exec_tb.sv */
// rv64 exec testbench driving seeded random RV64IM instructions into the exec slice
`include "rv64_exec_params.svh"

module rv64_exec_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int      N_INST     = 2000;
  localparam int      HALT_EVERY = 500;
  localparam int      RST_CYC    = 16;
  localparam int      MAX_CYC    = 8;
  localparam longint  PERIOD     = 20;
  localparam longint  TIMEOUT_NS =
    (longint'(N_INST) * MAX_CYC + RST_CYC * (N_INST / HALT_EVERY + 1)) * PERIOD;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic             clk;
  logic             rst;
  logic             valid;
  logic [31:0]      inst;
  logic [`XLEN-1:0] pc, rs1_val, rs2_val, rdata;
  logic             out_valid, halt, illegal;
  logic [`XLEN-1:0] busw, alu_result, nextpc;
  logic             done;
  int               checks, errors;
  integer           seed;

  rv64_exec_top dut_i (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_valid      (valid),
    .i_inst       (inst),
    .i_pc         (pc),
    .i_rs1_val    (rs1_val),
    .i_rs2_val    (rs2_val),
    .i_rdata      (rdata),
    .o_valid      (out_valid),
    .o_busw       (busw),
    .o_alu_result (alu_result),
    .o_nextpc     (nextpc),
    .o_halt       (halt),
    .o_illegal    (illegal)
  );

  rv64_exec_checker chk_i (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_valid      (valid),
    .i_inst       (inst),
    .i_pc         (pc),
    .i_rs1_val    (rs1_val),
    .i_rs2_val    (rs2_val),
    .i_rdata      (rdata),
    .i_out_valid  (out_valid),
    .i_busw       (busw),
    .i_alu_result (alu_result),
    .i_nextpc     (nextpc),
    .i_halt       (halt),
    .i_illegal    (illegal),
    .i_done       (done),
    .o_checks     (checks),
    .o_errors     (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog timeout, the stimulus did not finish in %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  // corner values feed the divide-by-zero and overflow cases
  task automatic pick_operand(output logic [63:0] v);
    case ({$random(seed)} % 8)
      0:       v = 64'd0;
      1:       v = 64'h8000_0000_0000_0000;
      2:       v = '1;
      3:       v = {60'd0, 4'($random(seed))};
      4:       v = 64'hffff_ffff_8000_0000;
      default: v = {$random(seed), $random(seed)};
    endcase
  endtask

  task automatic make_inst(output logic [31:0] w);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [4:0]  rd, rs1f, rs2f;
    logic [31:0] sel;
    logic        alt;
    f3   = 3'($random(seed));
    imm  = 12'($random(seed));
    rd   = 5'($random(seed));
    rs1f = 5'($random(seed));
    rs2f = 5'($random(seed));
    sel  = $random(seed);
    alt  = sel[2];
    f7   = `F7_BASE;
    case ({$random(seed)} % 10)
      0: begin
        if (f3 == 3'd0 || f3 == 3'd5)
          f7 = alt ? `F7_ALT : `F7_BASE;
        w = {f7, rs2f, rs1f, f3, rd, `OP_REG};
      end
      1: begin
        if (f3 == 3'd1)
          imm[11:6] = 6'd0;
        if (f3 == 3'd5)
          imm[11:6] = alt ? 6'b010000 : 6'd0;
        w = {imm, rs1f, f3, rd, `OP_IMM};
      end
      2: begin
        f3 = (sel[4:3] == 2'd0) ? 3'd0 : (sel[4:3] == 2'd1) ? 3'd1 : 3'd5;
        if (sel[0]) begin
          if (f3 != 3'd1)
            f7 = alt ? `F7_ALT : `F7_BASE;
          w = {f7, rs2f, rs1f, f3, rd, `OP_REG32};
        end else begin
          // addiw keeps its full signed immediate
          if (f3 != 3'd0)
            imm[11:5] = (f3 == 3'd5 && alt) ? `F7_ALT : `F7_BASE;
          w = {imm, rs1f, f3, rd, `OP_IMM32};
        end
      end
      3: begin
        if (sel[0]) begin
          w = {`F7_MULDIV, rs2f, rs1f, f3, rd, `OP_REG};
        end else begin
          // only mulw and the divides exist in word form
          if (f3 != 3'd0 && !f3[2])
            f3 = 3'd0;
          w = {`F7_MULDIV, rs2f, rs1f, f3, rd, `OP_REG32};
        end
      end
      4: begin
        if (f3 == 3'd7)
          f3 = 3'd6;
        w = {imm, rs1f, f3, rd, `OP_LOAD};
      end
      5: begin
        if (f3 == 3'd2 || f3 == 3'd3)
          f3[2] = 1'b1;
        w = {sel[31:25], rs2f, rs1f, f3, sel[11:7], `OP_BRANCH};
      end
      6: begin
        if (sel[0])
          w = {sel[31:12], rd, `OP_JAL};
        else
          w = {imm, rs1f, 3'd0, rd, `OP_JALR};
      end
      7: w = {sel[31:12], rd, sel[1] ? `OP_LUI : `OP_AUIPC};
      8: begin
        f3[2] = 1'b0;
        w = {sel[31:25], rs2f, rs1f, f3, sel[11:7], `OP_STORE};
      end
      default: begin
        case (sel[1:0])
          2'd0:    w = {sel[31:7], 7'b0001011};
          2'd1:    w = {sel[31:7], 7'b0101011};
          2'd2:    w = {sel[31:7], 7'b1011011};
          default: w = {sel[31:7], 7'b1111111};
        endcase
      end
    endcase
  endtask

  task automatic drive_inst(input logic [31:0] w);
    logic [63:0] a, b;
    pick_operand(a);
    pick_operand(b);
    // equal operands give the beq and bge edge
    if ({$random(seed)} % 4 == 0)
      b = a;
    @(negedge clk);
    valid   = 1'b1;
    inst    = w;
    pc      = {$random(seed), $random(seed)} & ~64'd3;
    rs1_val = a;
    rs2_val = b;
    rdata   = {$random(seed), $random(seed)};
  endtask

  task automatic drive_idle();
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst   = 1'b1;
    valid = 1'b0;
    repeat (RST_CYC) @(negedge clk);
    rst = 1'b0;
  endtask

  initial begin
    logic [31:0] w;
    seed    = 32'h5ee0;
    rst     = 1'b1;
    valid   = 1'b0;
    inst    = 32'd0;
    pc      = '0;
    rs1_val = '0;
    rs2_val = '0;
    rdata   = '0;
    done    = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      if ({$random(seed)} % 6 == 0)
        drive_idle();
      if (n % HALT_EVERY == HALT_EVERY - 1) begin
        drive_inst(EBREAK);
        // these must be dropped while halted
        repeat (3) begin
          make_inst(w);
          drive_inst(w);
        end
        apply_reset();
      end else begin
        make_inst(w);
        drive_inst(w);
      end
    end
    repeat (3) drive_idle();
    @(posedge clk);
    done = 1'b1;
    #1;
    if (errors == 0 && checks > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rv64_exec.f */
+incdir+src
src/rv64_exec_pkg.sv
src/rv64_idu.sv
src/rv64_issue_reg.sv
src/rv64_exu.sv
src/rv64_exec_top.sv
dv/rv64_exec_checker.sv
dv/rv64_exec_tb.sv

/* run.sh */
#!/bin/sh
# builds the rv64 exec testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f rv64_exec.f \
  --top-module rv64_exec_tb \
  -o rv64_exec_sim

./obj_dir/rv64_exec_sim > sim.log 2>&1
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
else
  exit 1
fi
